/* memmap.f */
memmap_pkg.sv
memmap_front.sv
memmap_regs.sv
memmap_decode.sv
memmap_issue.sv
memmap_top.sv
tb_memmap.sv

/* memmap_decode.sv */
// Mapper region decode stage
// Priority match over eight regions, writes mapper registers on unmapped writes

module memmap_decode
    import memmap_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // Stage 1
    input  logic                 s1_valid,
    input  logic [ADDR_W-1:0]    s1_addr,
    input  logic                 s1_wr,
    input  logic [15:0]          s1_wdata,
    input  logic [1:0]           s1_be,

    input  logic [NREGION*8-1:0] region_base,
    input  logic [NREGION*2-1:0] region_size,

    // Register write, lands on the same edge as stage 2
    output logic                 cpu_mmr_wr,
    output logic [MMR_IDX_W-1:0] cpu_mmr_idx,
    output logic [7:0]           cpu_mmr_data,

    // Stage 2 towards issue
    output logic                 s2_valid,
    output logic [ADDR_W-1:0]    s2_addr,
    output logic                 s2_wr,
    output logic [15:0]          s2_wdata,
    output logic [1:0]           s2_be,
    output logic [NREGION-1:0]   s2_region,
    output logic                 s2_drop     // Unmapped access, credit goes back
);

    logic [NREGION-1:0] hit;       // Every region that matches
    logic [NREGION-1:0] sel;       // Lowest one only
    logic               unmapped;

    // Compare byte address bits 23:16 under the size mask
    always_comb begin
        for (int r = 0; r < NREGION; r++) begin
            hit[r] = ((s1_addr[ADDR_W-1 -: 8] ^ region_base[r*8 +: 8])
                      & size_mask(region_size_e'(region_size[r*2 +: 2]))) == 8'h00;
        end
    end

    assign sel      = hit & (~hit + {{(NREGION-1){1'b0}}, 1'b1});  // Isolate lowest set bit
    assign unmapped = s1_valid && (hit == '0);

    // Unmapped write with low lane on programs the mapper
    assign cpu_mmr_wr   = unmapped && s1_wr && !s1_be[0];
    assign cpu_mmr_idx  = s1_addr[MMR_IDX_W-1:0];   // Byte address bits 5:1
    assign cpu_mmr_data = s1_wdata[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s2_valid <= 1'b0;
            s2_drop  <= 1'b0;
        end else begin
            s2_valid <= s1_valid && !unmapped;
            s2_drop  <= unmapped;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_addr   <= s1_addr;
            s2_wr     <= s1_wr;
            s2_wdata  <= s1_wdata;
            s2_be     <= s1_be;
            s2_region <= sel;
        end
    end

    // Issued accesses carry exactly one region
    a_region_onehot: assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> $onehot(s2_region))
        else $error("stage 2 region not one-hot: %h", s2_region);

endmodule

/* memmap_front.sv */
// Mapper front stage
// Captures CPU bus cycles and runs the vertical-blank interrupt with its acknowledge

module memmap_front
    import memmap_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // CPU request for each spent credit
    input  logic              req_valid,
    input  logic [ADDR_W-1:0] req_addr,
    input  logic              req_wr,
    input  logic [15:0]       req_wdata,
    input  logic [1:0]        req_be,     // Active low lanes as on dswn
    input  logic [2:0]        req_fc,

    input  logic              vint,

    // Stage 1 towards decode
    output logic              s1_valid,
    output logic [ADDR_W-1:0] s1_addr,
    output logic              s1_wr,
    output logic [15:0]       s1_wdata,
    output logic [1:0]        s1_be,

    output logic              irq_n
);

    logic intack;      // IACK cycle accepted this clock
    logic last_vint;   // Previous vint sample
    logic vint_rise;

    assign intack    = req_valid && (req_fc == 3'(FC_INTACK));
    assign vint_rise = vint && !last_vint;

    // Stage 1 valid follows the request every cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req_valid;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (req_valid) begin
            s1_addr  <= req_addr;
            s1_wr    <= req_wr && !intack;  // IACK passes on as a read
            s1_wdata <= req_wdata;
            s1_be    <= req_be;
        end
    end

    // VBLANK interrupt
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            irq_n     <= 1'b1;
        end else begin
            last_vint <= vint;
            if (intack) begin
                irq_n <= 1'b1;      // Acknowledge beats a new edge
            end else if (vint_rise) begin
                irq_n <= 1'b0;
            end
        end
    end

endmodule

/* memmap_issue.sv */
// Mapper issue stage
// Queues decoded accesses, sends on memory credits and returns requester credits

module memmap_issue
    import memmap_pkg::*;
#(
    parameter int QDEPTH      = 4,
    parameter int MEM_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst,

    // Stage 2
    input  logic               s2_valid,
    input  logic [ADDR_W-1:0]  s2_addr,
    input  logic               s2_wr,
    input  logic [15:0]        s2_wdata,
    input  logic [1:0]         s2_be,
    input  logic [NREGION-1:0] s2_region,
    input  logic               s2_drop,

    // Memory side
    input  logic               mem_credit,   // One credit back per pulse
    output logic               mem_valid,
    output logic [ADDR_W-1:0]  mem_addr,
    output logic               mem_wr,
    output logic [15:0]        mem_wdata,
    output logic [1:0]         mem_be,
    output logic [NREGION-1:0] mem_region,

    output logic [1:0]         req_credit    // Credits back to the requester
);

    localparam int PTR_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
    localparam int CNT_W  = $clog2(QDEPTH + 1);
    localparam int CRED_W = $clog2(MEM_CREDITS + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(QDEPTH - 1);

    // Queue storage
    logic [ADDR_W-1:0]  q_addr   [QDEPTH];
    logic               q_wr     [QDEPTH];
    logic [15:0]        q_wdata  [QDEPTH];
    logic [1:0]         q_be     [QDEPTH];
    logic [NREGION-1:0] q_region [QDEPTH];

    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [CNT_W-1:0]  q_count;
    logic [CRED_W-1:0] mem_cnt;   // Memory credits held

    assign mem_valid  = (q_count != '0) && (mem_cnt != '0);  // Head goes out
    assign mem_addr   = q_addr[rd_ptr];
    assign mem_wr     = q_wr[rd_ptr];
    assign mem_wdata  = q_wdata[rd_ptr];
    assign mem_be     = q_be[rd_ptr];
    assign mem_region = q_region[rd_ptr];

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            q_addr[wr_ptr]   <= s2_addr;
            q_wr[wr_ptr]     <= s2_wr;
            q_wdata[wr_ptr]  <= s2_wdata;
            q_be[wr_ptr]     <= s2_be;
            q_region[wr_ptr] <= s2_region;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            mem_cnt    <= CRED_W'(MEM_CREDITS);
            req_credit <= 2'd0;
        end else begin
            if (s2_valid) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (mem_valid) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            q_count <= q_count + CNT_W'(s2_valid) - CNT_W'(mem_valid);
            mem_cnt <= mem_cnt + CRED_W'(mem_credit) - CRED_W'(mem_valid);
            // One back per send and per drop
            req_credit <= {1'b0, mem_valid} + {1'b0, s2_drop};
        end
    end

    // Requester credits must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        s2_valid |-> (q_count < CNT_W'(QDEPTH)))
        else $error("push into full issue queue");

    // Memory never returns more than it granted
    a_mem_credit: assert property (@(posedge clk) disable iff (rst)
        mem_cnt <= CRED_W'(MEM_CREDITS))
        else $error("memory credit count above limit: %0d", mem_cnt);

endmodule

/* memmap_pkg.sv */
// Memory mapper shared definitions
// Region size codes, mapper register layout and bus constants

package memmap_pkg;

    localparam int NREGION   = 8;   // Programmable regions
    localparam int ADDR_W    = 23;  // CPU word address, byte bits 23:1
    localparam int FC_INTACK = 7;   // Function code of an IACK cycle

    // Mapper register file layout
    localparam int MMR_NUM      = 32;
    localparam int MMR_IDX_W    = 5;
    localparam int MMR_BASE_IDX = 16;  // Base byte of region 0
    localparam int MMR_SIZE_IDX = 17;  // Size code of region 0
    localparam int MMR_STRIDE   = 2;   // Registers per region

    // Region size, sets how many upper address bits are compared
    typedef enum logic [1:0] {
        SIZE_64K  = 2'd0,  // 8 bits
        SIZE_128K = 2'd1,  // 7 bits
        SIZE_512K = 2'd2,  // 5 bits
        SIZE_2M   = 2'd3   // 3 bits
    } region_size_e;

    // Mask over byte address bits 23:16 for a given size
    function automatic logic [7:0] size_mask(region_size_e sz);
        logic [7:0] m;
        case (sz)
            SIZE_64K:  m = 8'hff;
            SIZE_128K: m = 8'hfe;
            SIZE_512K: m = 8'hf8;
            SIZE_2M:   m = 8'he0;
            default:   m = 8'hff;
        endcase
        return m;
    endfunction

endpackage

/* memmap_regs.sv */
// Mapper register file
// 32 byte registers written by the CPU path and the MCU port, region fields exposed flat

module memmap_regs
    import memmap_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Write from the decode stage, unmapped CPU writes
    input  logic                   cpu_mmr_wr,
    input  logic [MMR_IDX_W-1:0]   cpu_mmr_idx,
    input  logic [7:0]             cpu_mmr_data,

    // Microcontroller port
    input  logic                   mcu_wr,
    input  logic [MMR_IDX_W-1:0]   mcu_addr,
    input  logic [7:0]             mcu_wdata,

    // Per-region fields
    output logic [NREGION*8-1:0]   region_base,
    output logic [NREGION*2-1:0]   region_size
);

    logic [7:0] mmr [MMR_NUM];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // All zero, every region at base 0 with 64 kB
            for (int i = 0; i < MMR_NUM; i++) begin
                mmr[i] <= 8'h00;
            end
        end else begin
            if (cpu_mmr_wr) begin
                mmr[cpu_mmr_idx] <= cpu_mmr_data;
            end
            // Same index in the same cycle, MCU takes it
            if (mcu_wr) begin
                mmr[mcu_addr] <= mcu_wdata;
            end
        end
    end

    // Base byte at 16+2r, size code in low bits of 17+2r
    genvar r;
    generate
        for (r = 0; r < NREGION; r++) begin : g_region
            assign region_base[r*8 +: 8] = mmr[MMR_BASE_IDX + MMR_STRIDE*r];
            assign region_size[r*2 +: 2] = mmr[MMR_SIZE_IDX + MMR_STRIDE*r][1:0];
        end
    endgenerate

endmodule

/* memmap_top.sv */
// Memory mapper top level
// Front, decode and issue stages around the mapper register file

module memmap_top
    import memmap_pkg::*;
#(
    parameter int QDEPTH      = 4,
    parameter int MEM_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    // CPU requester
    input  logic                 req_valid,
    input  logic [ADDR_W-1:0]    req_addr,
    input  logic                 req_wr,
    input  logic [15:0]          req_wdata,
    input  logic [1:0]           req_be,
    input  logic [2:0]           req_fc,
    output logic [1:0]           req_credit,
    // Microcontroller register port
    input  logic                 mcu_wr,
    input  logic [MMR_IDX_W-1:0] mcu_addr,
    input  logic [7:0]           mcu_wdata,
    // Memory side
    output logic                 mem_valid,
    output logic [ADDR_W-1:0]    mem_addr,
    output logic                 mem_wr,
    output logic [15:0]          mem_wdata,
    output logic [1:0]           mem_be,
    output logic [NREGION-1:0]   mem_region,
    input  logic                 mem_credit,
    // Interrupt
    input  logic                 vint,
    output logic                 irq_n
);

    logic                 s1_valid, s1_wr, s2_valid, s2_wr, s2_drop;
    logic [ADDR_W-1:0]    s1_addr, s2_addr;
    logic [15:0]          s1_wdata, s2_wdata;
    logic [1:0]           s1_be, s2_be;
    logic [NREGION-1:0]   s2_region;
    logic [NREGION*8-1:0] region_base;
    logic [NREGION*2-1:0] region_size;
    logic                 cpu_mmr_wr;
    logic [MMR_IDX_W-1:0] cpu_mmr_idx;
    logic [7:0]           cpu_mmr_data;

    memmap_front u_front (.*);
    memmap_regs u_regs (.*);
    memmap_decode u_decode (.*);
    memmap_issue #(.QDEPTH(QDEPTH), .MEM_CREDITS(MEM_CREDITS)) u_issue (.*);

endmodule

/* tb_memmap.sv */
// Memory mapper testbench
// Table-driven requests with requester, memory and register models and an in-order scoreboard

module tb_memmap
    import memmap_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int QDEPTH      = 4;
    localparam int MEM_CREDITS = 2;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid, req_wr, mcu_wr, mem_credit, vint;
    logic [ADDR_W-1:0]    req_addr;
    logic [15:0]          req_wdata;
    logic [1:0]           req_be;
    logic [2:0]           req_fc;
    logic [MMR_IDX_W-1:0] mcu_addr;
    logic [7:0]           mcu_wdata;
    logic [1:0]           req_credit, mem_be;
    logic                 mem_valid, mem_wr, irq_n;
    logic [ADDR_W-1:0]    mem_addr;
    logic [15:0]          mem_wdata;
    logic [NREGION-1:0]   mem_region;

    // Entry is byte address, write, data, lanes, fc, region (zero when unmapped)
    logic [53:0] table_q [$];
    logic [49:0] expect_q [$];   // Region, lanes, data, write, word address
    logic [49:0] head;
    logic [7:0]  shadow [32];    // Reference copy of the mapper registers
    int     credits, owed, wait_cnt, sent, returned, xfers, errors, cycles;
    int     limit, mark, passed, failed, s0, x0;
    integer seed;
    bit     hold;                // Memory withholds credits

    memmap_top #(.QDEPTH(QDEPTH), .MEM_CREDITS(MEM_CREDITS)) uut (.*);

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic add_entry(input logic [23:0] addr, input logic wr, input logic [15:0] data,
                             input logic [1:0] be, input logic [2:0] fc, input logic [7:0] rgn);
        table_q.push_back({addr, wr, data, be, fc, rgn});
    endtask

    // Lowest region whose upper address bits match under its size code
    function automatic logic [7:0] ref_region(input logic [23:0] addr);
        int sh;
        for (int r = 0; r < NREGION; r++) begin
            sh = (shadow[17+2*r][1:0] == 2'd0) ? 0 : (shadow[17+2*r][1:0] == 2'd1) ? 1 :
                 (shadow[17+2*r][1:0] == 2'd2) ? 3 : 5;   // Ignored low bits of the byte
            if ((addr[23:16] >> sh) == (shadow[16+2*r] >> sh))
                return 8'(1 << r);
        end
        return 8'h00;
    endfunction

    // Sends one request and updates the models
    task automatic send(input int i);
        logic [53:0] e;
        logic [7:0]  exp_r;
        e = table_q[i];
        while (credits == 0) @(negedge clk);
        exp_r     = ref_region(e[53:30]);
        check("table_region", exp_r, e[7:0]);
        req_valid = 1'b1;
        req_addr  = e[53:31];   // Byte bits 23:1
        req_wr    = e[29];
        req_wdata = e[28:13];
        req_be    = e[12:11];
        req_fc    = e[10:8];
        credits--;
        sent++;
        if (exp_r == 8'h00 && e[29] && !e[11])
            shadow[e[35:31]] = e[20:13];   // Unmapped write programs a register
        else if (exp_r != 8'h00)
            expect_q.push_back({exp_r, e[12:11], e[28:13],
                                e[29] && e[10:8] != 3'(FC_INTACK), e[53:31]});
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic mcu_write(input logic [4:0] idx, input logic [7:0] data);
        mcu_wr    = 1'b1;
        mcu_addr  = idx;
        mcu_wdata = data;
        shadow[idx] = data;
        @(negedge clk);
        mcu_wr = 1'b0;
    endtask

    // Everything issued and every memory credit back
    task automatic drain();
        while (credits < QDEPTH || owed != 0) @(negedge clk);
        check("expect_q_size", expect_q.size(), 0);
    endtask

    task automatic report(input string name);
        if (errors == mark) begin
            passed++;
            $display("PASS %s", name);
        end else begin
            failed++;
            $display("FAIL %s, %0d errors", name, errors - mark);
        end
        mark = errors;
    endtask

    // Credit counting and scoreboard
    always @(posedge clk) begin
        if (!rst) begin
            credits  += req_credit;
            returned += req_credit;
            if (mem_valid) begin
                xfers++;
                owed++;
                if (expect_q.size() == 0) begin
                    errors++;
                    $display("Memory transfer with nothing expected at %0t", $time);
                end else begin
                    head = expect_q.pop_front();
                    check("mem_addr", mem_addr, head[22:0]);
                    check("mem_wr", mem_wr, head[23]);
                    check("mem_wdata", mem_wdata, head[39:24]);
                    check("mem_be", mem_be, head[41:40]);
                    check("mem_region", mem_region, head[49:42]);
                end
            end
        end
    end

    // Memory returns each credit after a random wait
    always @(negedge clk) begin
        mem_credit = 1'b0;
        if (!hold && owed > 0) begin
            if (wait_cnt == 0) begin
                mem_credit = 1'b1;
                owed--;
                wait_cnt = $random(seed) & 3;
            end else begin
                wait_cnt--;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout, no finish after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed      = 87;
        limit     = 1000000;
        credits   = QDEPTH;
        rst       = 1'b1;
        req_valid = 1'b0;
        req_addr  = '0;
        req_wr    = 1'b0;
        req_wdata = '0;
        req_be    = 2'b11;
        req_fc    = '0;
        mcu_wr    = 1'b0;
        mcu_addr  = '0;
        mcu_wdata = '0;
        mem_credit = 1'b0;
        vint      = 1'b0;
        for (int k = 0; k < 32; k++) shadow[k] = 8'h00;
        add_entry(24'h000100, 0, 16'h0000, 2'b00, 3'd5, 8'h01);
        add_entry(24'h00fffe, 1, 16'h1234, 2'b00, 3'd5, 8'h01);
        add_entry(24'hf00024, 1, 16'h0020, 2'b10, 3'd5, 8'h00);   // Region 1 base
        add_entry(24'hf00026, 1, 16'h0001, 2'b10, 3'd5, 8'h00);   // 128 kB
        add_entry(24'hf00028, 1, 16'h0040, 2'b10, 3'd5, 8'h00);
        add_entry(24'hf0002a, 1, 16'h0002, 2'b10, 3'd5, 8'h00);   // 512 kB
        add_entry(24'hf0002c, 1, 16'h0080, 2'b10, 3'd5, 8'h00);
        add_entry(24'hf0002e, 1, 16'h0003, 2'b10, 3'd5, 8'h00);   // 2 MB
        add_entry(24'h200000, 0, 16'h0000, 2'b00, 3'd5, 8'h02);
        add_entry(24'h21fffe, 0, 16'h0000, 2'b00, 3'd5, 8'h02);
        add_entry(24'h220000, 0, 16'h0000, 2'b00, 3'd5, 8'h00);
        add_entry(24'h400000, 1, 16'ha55a, 2'b01, 3'd5, 8'h04);
        add_entry(24'h47fffe, 0, 16'h0000, 2'b00, 3'd5, 8'h04);
        add_entry(24'h800000, 0, 16'h0000, 2'b00, 3'd5, 8'h08);
        add_entry(24'h9ffffe, 1, 16'hbeef, 2'b00, 3'd5, 8'h08);
        add_entry(24'ha00000, 0, 16'h0000, 2'b00, 3'd5, 8'h00);
        add_entry(24'hf00030, 1, 16'h0044, 2'b10, 3'd5, 8'h00);   // Region 4 inside region 2
        add_entry(24'h440000, 0, 16'h0000, 2'b00, 3'd5, 8'h04);
        add_entry(24'hc10000, 1, 16'hc0de, 2'b00, 3'd5, 8'h20);
        add_entry(24'hf00038, 1, 16'h0011, 2'b10, 3'd5, 8'h00);   // Loses to the MCU
        add_entry(24'hd00000, 0, 16'h0000, 2'b00, 3'd5, 8'h40);
        add_entry(24'h110000, 0, 16'h0000, 2'b00, 3'd5, 8'h00);
        add_entry(24'h000200, 1, 16'h1000, 2'b00, 3'd5, 8'h01);
        add_entry(24'h400202, 0, 16'h0000, 2'b00, 3'd5, 8'h04);
        add_entry(24'h000204, 1, 16'h1002, 2'b00, 3'd5, 8'h01);
        add_entry(24'h800206, 1, 16'h1003, 2'b00, 3'd5, 8'h08);
        add_entry(24'h000208, 0, 16'h0000, 2'b00, 3'd5, 8'h01);
        add_entry(24'h20020a, 1, 16'h1005, 2'b00, 3'd5, 8'h02);
        add_entry(24'h00020c, 1, 16'h1006, 2'b00, 3'd5, 8'h01);
        add_entry(24'h000010, 0, 16'h0000, 2'b00, 3'd7, 8'h01);   // IACK
        limit = table_q.size() * 40 + 200;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (3) begin
            @(negedge clk);
            check("irq_n", irq_n, 1);
            check("mem_valid", mem_valid, 0);
            check("req_credit", req_credit, 0);
        end
        send(0);
        send(1);
        drain();
        report("reset state and default region 0");

        for (int i = 2; i < 16; i++) send(i);
        drain();
        report("CPU programmed regions and unmapped drops");

        send(16);
        send(17);
        drain();
        mcu_write(5'd26, 8'hc0);   // Region 5 at 0xc00000 with 128 kB
        mcu_write(5'd27, 8'h01);
        send(18);
        send(19);
        mcu_write(5'd28, 8'hd0);   // Lands on the CPU write edge
        send(20);
        send(21);
        drain();
        report("overlap priority and MCU port");

        hold = 1'b1;
        s0   = sent;
        x0   = xfers;
        fork
            for (int i = 22; i < 29; i++) send(i);
        join_none
        repeat (24) @(negedge clk);
        check("mem_transfers", xfers - x0, MEM_CREDITS);
        check("queued", sent - s0 - (xfers - x0), QDEPTH);
        hold = 1'b0;
        wait (sent == s0 + 7);
        drain();
        report("memory back-pressure");

        vint = 1'b1;
        @(negedge clk);
        check("irq_n", irq_n, 0);
        repeat (3) @(negedge clk);
        check("irq_n", irq_n, 0);   // Held until acknowledged
        send(29);
        check("irq_n", irq_n, 1);
        vint = 1'b0;
        @(negedge clk);
        vint = 1'b1;
        @(negedge clk);
        check("irq_n", irq_n, 0);
        drain();
        check("req_credit_total", returned, sent);
        report("vblank interrupt and credit total");

        $display("Tests %0d passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
